// ==== design/rx_pkg.sv ====
package rx_pkg;

    // Serial framing constants.
    localparam int BYTE_W  = 8;
    localparam int PHASE_W = 3;

    // Sent repeatedly ahead of each frame.
    localparam logic [BYTE_W-1:0] PREAMBLE = 8'h5A;

    // First byte after the preamble and any filler.
    localparam logic [BYTE_W-1:0] SYNC_WORD = 8'h01;

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [PHASE_W-1:0] phase_t;

    // Aligner states.
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        HUNT    = 2'd1,
        CONFIRM = 2'd2,
        LOCKED  = 2'd3
    } align_state_t;

    // Frame reader states.
    typedef enum logic [1:0] {
        WAIT      = 2'd0,
        SEEK_SYNC = 2'd1,
        READ      = 2'd2
    } frame_state_t;

    // One tick per byte, so the phase counter must cover a whole byte.
    localparam int PHASES = 1 << PHASE_W;

    typedef logic [$clog2(PHASES)-1:0] phase_chk_t;

    localparam phase_t PHASE_START = '0;

endpackage

// ==== design/align_if.sv ====
`timescale 1ns/1ps

interface align_if
    import rx_pkg::*;
();

    logic  locked;
    logic  byte_tick;
    byte_t byte_data;

    // Ends the frame and sends the aligner back to idle.
    logic  frame_release;

    modport aligner (
        output locked,
        output byte_tick,
        output byte_data,
        input  frame_release
    );

    modport reader (
        input  locked,
        input  byte_tick,
        input  byte_data,
        output frame_release
    );

endinterface

// ==== design/preamble_aligner.sv ====
`timescale 1ns/1ps

module preamble_aligner
    import rx_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    fire,
    input  logic    din,
    align_if.aligner bus
);

    align_state_t state;
    align_state_t state_nxt;

    byte_t  shift_reg;
    phase_t phase;
    phase_t lock_phase;

    logic preamble_hit;
    logic at_lock_phase;
    logic tick_nxt;
    logic clear;

    assign preamble_hit  = (shift_reg == PREAMBLE);
    assign at_lock_phase = (phase == lock_phase);

    // Shift register and counter restart with every new frame.
    assign clear = (state == IDLE) || bus.frame_release;

    // The confirming byte is the first one presented.
    always_comb begin
        tick_nxt = 1'b0;
        if (at_lock_phase && !bus.frame_release) begin
            if (state == LOCKED) begin
                tick_nxt = 1'b1;
            end else if (state == CONFIRM && preamble_hit) begin
                tick_nxt = 1'b1;
            end
        end
    end

    assign bus.locked = (state == LOCKED);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (fire) begin
                    state_nxt = HUNT;
                end
            end
            HUNT: begin
                // Any of the eight phases may carry the first match.
                if (preamble_hit) begin
                    state_nxt = CONFIRM;
                end
            end
            CONFIRM: begin
                // Same phase, one byte later.
                if (at_lock_phase) begin
                    if (preamble_hit) begin
                        state_nxt = LOCKED;
                    end else begin
                        state_nxt = HUNT;
                    end
                end
            end
            LOCKED: begin
                state_nxt = LOCKED;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase

        if (bus.frame_release) begin
            state_nxt = IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Most significant bit arrives first.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (clear) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= {shift_reg[BYTE_W-2:0], din};
        end
    end

    // Free running, wraps once per byte.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= PHASE_START;
        end else if (clear) begin
            phase <= PHASE_START;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_phase <= PHASE_START;
        end else if (state == HUNT && preamble_hit) begin
            lock_phase <= phase;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.byte_tick <= 1'b0;
        end else begin
            bus.byte_tick <= tick_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (tick_nxt) begin
            bus.byte_data <= shift_reg;
        end
    end

endmodule

// ==== design/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader
    import rx_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    fire,
    align_if.reader bus,
    output byte_t   dout,
    output logic    byte_valid
);

    frame_state_t state;
    frame_state_t state_nxt;

    logic take;
    logic sync_seen;
    logic frame_end;

    // A payload byte is accepted on every tick while reading.
    assign take = (state == READ) && bus.byte_tick;

    assign sync_seen = (state == SEEK_SYNC) && bus.byte_tick
                       && (bus.byte_data == SYNC_WORD);

    // Fire low at a byte boundary closes the frame.
    assign frame_end = take && !fire;

    assign bus.frame_release = frame_end;

    always_comb begin
        state_nxt = state;
        case (state)
            WAIT: begin
                if (bus.locked) begin
                    state_nxt = SEEK_SYNC;
                end
            end
            SEEK_SYNC: begin
                // Extra preamble bytes and filler are dropped here.
                if (sync_seen) begin
                    state_nxt = READ;
                end
            end
            READ: begin
                if (frame_end) begin
                    state_nxt = WAIT;
                end
            end
            default: begin
                state_nxt = WAIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT;
        end else begin
            state <= state_nxt;
        end
    end

    // Last byte of a frame stays for one cycle, then zero.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (state == WAIT) begin
            dout <= '0;
        end else if (take) begin
            dout <= bus.byte_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= take;
        end
    end

endmodule

// ==== design/serial_rx_top.sv ====
`timescale 1ns/1ps

module serial_rx_top
    import rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fire,
    input  logic  din,
    output byte_t dout,
    output logic  byte_valid
);

    align_if bus ();

    // Finds the bit phase and hands over whole bytes.
    preamble_aligner preamble_aligner_i (
        .clk  (clk),
        .rst  (rst),
        .fire (fire),
        .din  (din),
        .bus  (bus.aligner)
    );

    // Skips to the sync word and delivers the payload.
    frame_reader frame_reader_i (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .bus        (bus.reader),
        .dout       (dout),
        .byte_valid (byte_valid)
    );

endmodule

// ==== sim/rx_clk_gen.sv ====
`timescale 1ns/1ps

module rx_clk_gen (
    output logic clk
);

    // 20 ns period.
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule

// ==== sim/serial_rx_asserts.sv ====
`timescale 1ns/1ps

module serial_rx_asserts
    import rx_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input byte_t dout,
    input logic  byte_valid
);

    int error_count = 0;

    // A strobe lasts exactly one cycle.
    single_strobe: assert property (@(posedge clk) disable iff (rst)
        byte_valid |=> !byte_valid)
        else begin
            $error("byte_valid high for two cycles in a row");
            error_count++;
        end

    // Outputs start clean.
    clean_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!byte_valid && dout == '0))
        else begin
            $error("byte_valid or dout not zero after reset release");
            error_count++;
        end

    // dout moves only with a strobe, or back to zero.
    dout_moves_with_strobe: assert property (@(posedge clk) disable iff (rst)
        (dout != $past(dout)) |-> (byte_valid || dout == '0))
        else begin
            $error("dout changed without byte_valid");
            error_count++;
        end

endmodule

bind serial_rx_top serial_rx_asserts asserts_i (
    .clk        (clk),
    .rst        (rst),
    .dout       (dout),
    .byte_valid (byte_valid)
);

// ==== sim/serial_rx_tb.sv ====
`timescale 1ns/1ps

module serial_rx_tb
    import rx_pkg::*;
();

    localparam int          NUM_ENTRIES   = 9;
    localparam int          RESET_CYCLES  = 5;
    localparam int unsigned SEED          = 32'h49d8_71dc;
    localparam int          BYTE_TIMEOUT  = 4 * BYTE_W;
    localparam int          CLEAR_TIMEOUT = 8;
    localparam int          QUIET_CYCLES  = 2 * BYTE_W;

    typedef struct {
        int lead_zeros;
        int preambles;
        int fillers;
        int payload_len;
        bit broken;
    } entry_t;

    logic  clk;
    logic  rst;
    logic  fire;
    logic  din;
    byte_t dout;
    logic  byte_valid;

    entry_t      stim [NUM_ENTRIES];
    byte_t       exp_q [$];
    byte_t       got_q [$];

    rx_clk_gen clk_gen_i (
        .clk (clk)
    );

    serial_rx_top serial_rx_top_i (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .din        (din),
        .dout       (dout),
        .byte_valid (byte_valid)
    );

    // Every strobed byte is kept.
    always @(negedge clk) begin
        if (!rst && byte_valid) begin
            got_q.push_back(dout);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("Simulation failed");
            $fatal(1, "value check on %s did not match", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "wait loop ran out of cycles");
    endtask

    task automatic drive_bit(input logic b, input logic f);
        @(posedge clk);
        din  <= b;
        fire <= f;
    endtask

    // Most significant bit first; fire drops with the final bit of the frame.
    task automatic serialize_byte(input byte_t b, input logic last);
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            drive_bit(b[i], !(last && i == 0));
        end
    endtask

    // Filler must look like neither preamble nor sync.
    function automatic byte_t pick_filler();
        byte_t b;
        do begin
            b = byte_t'($urandom());
        end while (b == PREAMBLE || b == SYNC_WORD);
        return b;
    endfunction

    task automatic await_bytes(input int count);
        int cycles;
        cycles = 0;
        while (got_q.size() < count) begin
            @(posedge clk);
            cycles++;
            if (cycles > BYTE_TIMEOUT) begin
                report_timeout("payload bytes on dout");
            end
        end
    endtask

    task automatic await_dout_clear();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (dout !== '0) begin
            @(negedge clk);
            cycles++;
            if (cycles > CLEAR_TIMEOUT) begin
                report_timeout("dout to return to zero after the frame");
            end
        end
    endtask

    task automatic run_entry(input entry_t e);
        byte_t b;
        exp_q.delete();
        got_q.delete();
        // This bit is lost while the aligner leaves idle.
        drive_bit(1'b0, 1'b1);
        repeat (e.lead_zeros) begin
            drive_bit(1'b0, 1'b1);
        end
        if (e.broken) begin
            serialize_byte(PREAMBLE, 1'b0);
            serialize_byte(8'h00, 1'b0);
        end
        repeat (e.preambles) begin
            serialize_byte(PREAMBLE, 1'b0);
        end
        repeat (e.fillers) begin
            serialize_byte(pick_filler(), 1'b0);
        end
        serialize_byte(SYNC_WORD, 1'b0);
        for (int i = 0; i < e.payload_len; i++) begin
            b = byte_t'($urandom());
            exp_q.push_back(b);
            serialize_byte(b, i == e.payload_len - 1);
        end
        drive_bit(1'b0, 1'b0);
        await_bytes(e.payload_len);
        await_dout_clear();
        // Frame is over, line stays quiet.
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("byte_valid", byte_valid, 1'b0);
            check_value("dout", dout, '0);
        end
        check_value("byte count", got_q.size(), e.payload_len);
        for (int i = 0; i < e.payload_len; i++) begin
            check_value("dout", got_q[i], exp_q[i]);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        // lead zeros, preambles, fillers, payload length, broken preamble
        stim = '{
            '{0, 2, 0, 4, 1'b0},
            '{1, 3, 2, 5, 1'b0},
            '{2, 2, 1, 3, 1'b0},
            '{3, 4, 0, 6, 1'b0},
            '{4, 2, 3, 2, 1'b1},
            '{5, 3, 1, 7, 1'b0},
            '{6, 2, 0, 1, 1'b0},
            '{7, 2, 2, 8, 1'b1},
            '{3, 5, 4, 5, 1'b0}
        };
        rst  <= 1'b1;
        fire <= 1'b0;
        din  <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_value("byte_valid", byte_valid, 1'b0);
        check_value("dout", dout, '0);

        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            run_entry(stim[idx]);
        end

        if (serial_rx_top_i.asserts_i.error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "assertion failures were reported during the run");
        end
    end

endmodule

// ==== src.f ====
design/rx_pkg.sv
design/align_if.sv
design/preamble_aligner.sv
design/frame_reader.sv
design/serial_rx_top.sv
sim/rx_clk_gen.sv
sim/serial_rx_asserts.sv
sim/serial_rx_tb.sv
